// ==== hw/xmatmul_pkg.sv ====
/*
 * Shared constants and types for the matrix-multiply offload front end.
 * Holds opcodes, the coprocessor CSR address, the register map of the
 * accelerator and the records passed between the three pipeline stages.
 */

`default_nettype none

package xmatmul_pkg;

  localparam int unsigned InstrWidth   = 32;
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned NumRs        = 3;
  localparam int unsigned NumCfgRegs   = 6;
  localparam int unsigned CfgOffsWidth = $clog2(NumCfgRegs);

  // Major opcodes, instr[6:0]
  localparam logic [6:0] OpMcnfig = 7'h0B;
  localparam logic [6:0] OpMarith = 7'h2B;
  localparam logic [6:0] OpCsr    = 7'h73;

  localparam logic [11:0] CsrMacfg = 12'h7C0; // Only CSR owned by the coprocessor

  // Accelerator register map
  localparam logic [DataWidth-1:0] CfgBaseAddr = 32'h40; // Word i at base + 4*i
  localparam logic [DataWidth-1:0] TriggerAddr = 32'h0;

  typedef struct packed {
    logic [InstrWidth-1:0]          instr;
    logic [NumRs-1:0][DataWidth-1:0] rs;
    logic                           rs_valid;
  } xm_issue_req_t;

  typedef enum logic [1:0] {
    KindNone,
    KindCfg,
    KindArith,
    KindCsr
  } xm_kind_e;

  typedef struct packed {
    logic                            valid;    // High on a completed issue transfer
    xm_kind_e                        kind;
    logic                            rs_valid;
    logic [InstrWidth-1:0]           instr;
    logic [NumRs-1:0][DataWidth-1:0] rs;
  } xm_decoded_t;

  typedef struct packed {
    logic                 req;
    logic                 wen;  // Low for a write
    logic [3:0]           be;
    logic [DataWidth-1:0] add;
    logic [DataWidth-1:0] data;
    logic [3:0]           id;
  } xm_reg_req_t;

  // Word 0..2 X/W/Z pointers, 3 M|K, 4 N, 5 MARITH instruction
  typedef logic [NumCfgRegs-1:0][DataWidth-1:0] xm_cfg_words_t;

endpackage

`default_nettype wire

// ==== hw/xmatmul_issue_decode.sv ====
/*
 * Issue stage of the offload front end. Classifies the instruction offered
 * by the core, answers ready/accept in the same cycle and forwards a decoded
 * record to the configuration stage. Purely combinational.
 */

`timescale 1ns/1ps
`default_nettype none

module xmatmul_issue_decode (
  input  logic                       issue_valid_i,
  input  xmatmul_pkg::xm_issue_req_t issue_req_i,
  input  logic                       busy_i,
  output logic                       issue_ready_o,
  output logic                       issue_accept_o,
  output xmatmul_pkg::xm_decoded_t   dec_o
);

  logic [6:0]            opcode;
  logic [11:0]           csr_addr;
  logic                  csr_hit;
  xmatmul_pkg::xm_kind_e kind;

  assign opcode   = issue_req_i.instr[6:0];
  assign csr_addr = issue_req_i.instr[31:20];
  assign csr_hit  = (csr_addr == xmatmul_pkg::CsrMacfg);

  always_comb begin : classify
    case (opcode)
      xmatmul_pkg::OpMcnfig: kind = xmatmul_pkg::KindCfg;
      xmatmul_pkg::OpMarith: kind = xmatmul_pkg::KindArith;
      xmatmul_pkg::OpCsr:    kind = xmatmul_pkg::KindCsr;
      default:               kind = xmatmul_pkg::KindNone;
    endcase
  end

  // Issue handshake response
  always_comb begin : respond
    issue_ready_o  = 1'b0;
    issue_accept_o = 1'b0;
    if (issue_valid_i) begin
      case (kind)
        xmatmul_pkg::KindCfg,
        xmatmul_pkg::KindArith: begin
          // Held off by the core while a job is still being written
          issue_ready_o  = ~busy_i;
          issue_accept_o = ~busy_i;
        end
        xmatmul_pkg::KindCsr: begin
          /* The core offloads every CSR access, so all of them are consumed
             here, but only the coprocessor CSR is accepted */
          issue_ready_o  = 1'b1;
          issue_accept_o = csr_hit;
        end
        default: begin
          issue_ready_o  = 1'b1; // Consumed and refused
          issue_accept_o = 1'b0;
        end
      endcase
    end
  end

  always_comb begin : forward
    dec_o.valid    = issue_valid_i & issue_ready_o;
    dec_o.kind     = kind;
    dec_o.rs_valid = issue_req_i.rs_valid;
    dec_o.instr    = issue_req_i.instr;
    dec_o.rs       = issue_req_i.rs;
  end

endmodule

`default_nettype wire

// ==== hw/xmatmul_cfg_collect.sv ====
/*
 * Configuration stage. Stores the six words sent to the accelerator,
 * raises a one-cycle job request when MARITH arrives with its operands
 * and keeps the front end busy until the writer is back in idle.
 */

`timescale 1ns/1ps
`default_nettype none

module xmatmul_cfg_collect (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       clear_i,
  input  xmatmul_pkg::xm_decoded_t   dec_i,
  input  logic                       writer_idle_i,
  output xmatmul_pkg::xm_cfg_words_t cfg_words_o,
  output logic                       job_req_o,
  output logic                       busy_o
);

  xmatmul_pkg::xm_cfg_words_t words_d, words_q;
  logic                       words_en;
  logic                       job_d, job_q;
  logic                       busy_q;
  logic                       left_idle_q; // Writer has started on the current job
  logic                       job_done;

  always_comb begin : layout
    words_d  = words_q;
    words_en = 1'b0;
    job_d    = 1'b0;
    if (dec_i.valid) begin
      case (dec_i.kind)
        xmatmul_pkg::KindCfg: begin
          if (dec_i.rs_valid) begin
            words_en   = 1'b1;
            words_d[3] = dec_i.rs[0]; // M in the low half, K in the high half
            words_d[4] = dec_i.rs[1]; // N
          end
        end
        xmatmul_pkg::KindArith: begin
          words_en   = 1'b1;
          words_d[5] = dec_i.instr; // Operation word kept even without operands
          if (dec_i.rs_valid) begin
            words_d[0] = dec_i.rs[0]; // X pointer
            words_d[1] = dec_i.rs[1]; // W pointer
            words_d[2] = dec_i.rs[2]; // Z pointer
            job_d      = 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin : word_regs
    if (!rst_ni) begin
      words_q <= '0;
    end else if (clear_i) begin
      words_q <= '0;
    end else if (words_en) begin
      words_q <= words_d;
    end
  end

  assign job_done = left_idle_q & writer_idle_i;

  always_ff @(posedge clk_i, negedge rst_ni) begin : busy_track
    if (!rst_ni) begin
      job_q       <= 1'b0;
      busy_q      <= 1'b0;
      left_idle_q <= 1'b0;
    end else if (clear_i) begin
      job_q       <= 1'b0;
      busy_q      <= 1'b0;
      left_idle_q <= 1'b0;
    end else begin
      job_q <= job_d;
      if (job_q) begin
        busy_q <= 1'b1;
      end else if (job_done) begin
        busy_q <= 1'b0;
      end
      if (job_done) begin
        left_idle_q <= 1'b0;
      end else if (busy_q && !writer_idle_i) begin
        left_idle_q <= 1'b1;
      end
    end
  end

  assign cfg_words_o = words_q;
  assign job_req_o   = job_q;
  assign busy_o      = job_q | (busy_q & ~job_done); // Released as soon as writer is idle

endmodule

`default_nettype wire

// ==== hw/xmatmul_cfg_writer.sv ====
/*
 * Register-bus stage. On a job request it writes the six configuration
 * words, one per grant, to the accelerator register file, pulses
 * start_cfg_o on the last one, then writes the trigger register once the
 * accelerator reports the configuration complete.
 */

`timescale 1ns/1ps
`default_nettype none

module xmatmul_cfg_writer (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       clear_i,
  input  logic                       job_req_i,
  input  xmatmul_pkg::xm_cfg_words_t cfg_words_i,
  input  logic                       cfg_complete_i,
  input  logic                       reg_gnt_i,
  output xmatmul_pkg::xm_reg_req_t   reg_req_o,
  output logic                       start_cfg_o,
  output logic                       idle_o
);

  typedef enum logic [1:0] {
    Idle,
    WriteCfg,
    Trigger
  } state_e;

  state_e                                 state_q, state_d;
  logic [xmatmul_pkg::CfgOffsWidth-1:0]   reg_offs_q;
  logic [xmatmul_pkg::DataWidth-1:0]      offs_ext;
  logic                                   count_rst, count_update;

  // Zero-extended word offset, used for the byte address
  assign offs_ext = {{(xmatmul_pkg::DataWidth-xmatmul_pkg::CfgOffsWidth){1'b0}}, reg_offs_q};

  always_ff @(posedge clk_i, negedge rst_ni) begin : state_reg
    if (!rst_ni) begin
      state_q <= Idle;
    end else if (clear_i) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin : offs_counter
    if (!rst_ni) begin
      reg_offs_q <= '0;
    end else if (clear_i || count_rst) begin
      reg_offs_q <= '0;
    end else if (count_update) begin
      reg_offs_q <= reg_offs_q + 1'b1;
    end
  end

  always_comb begin : cfg_fsm
    state_d      = state_q;
    count_rst    = 1'b0;
    count_update = 1'b0;
    start_cfg_o  = 1'b0;
    reg_req_o    = '0;
    reg_req_o.wen = 1'b0; // Every access is a write

    case (state_q)
      Idle: begin
        if (job_req_i) state_d = WriteCfg;
      end

      WriteCfg: begin
        reg_req_o.req  = 1'b1;
        reg_req_o.be   = '1;
        reg_req_o.add  = xmatmul_pkg::CfgBaseAddr + (offs_ext << 2);
        reg_req_o.data = cfg_words_i[reg_offs_q];
        if (reg_gnt_i) begin
          count_update = 1'b1;
          if (reg_offs_q == xmatmul_pkg::CfgOffsWidth'(xmatmul_pkg::NumCfgRegs - 1)) begin
            // Last word accepted, accelerator may start loading its config
            count_rst   = 1'b1;
            start_cfg_o = 1'b1;
            state_d     = Trigger;
          end
        end
      end

      Trigger: begin
        if (cfg_complete_i) begin
          reg_req_o.req  = 1'b1;
          reg_req_o.be   = '1;
          reg_req_o.add  = xmatmul_pkg::TriggerAddr;
          reg_req_o.data = '0;
          if (reg_gnt_i) state_d = Idle;
        end
      end

      default: state_d = Idle;
    endcase
  end

  assign idle_o = (state_q == Idle);

endmodule

`default_nettype wire

// ==== hw/xmatmul_offload.sv ====
/*
 * Top of the coprocessor offload front end. Chains issue decode,
 * configuration collect and register-bus writing between the core issue
 * port and the accelerator peripheral bus.
 */

`timescale 1ns/1ps
`default_nettype none

module xmatmul_offload (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       clear_i,
  input  logic                       issue_valid_i,
  input  xmatmul_pkg::xm_issue_req_t issue_req_i,
  output logic                       issue_ready_o,
  output logic                       issue_accept_o,
  output xmatmul_pkg::xm_reg_req_t   reg_req_o,
  input  logic                       reg_gnt_i,
  input  logic                       cfg_complete_i,
  output logic                       start_cfg_o
);

  xmatmul_pkg::xm_decoded_t   dec;
  xmatmul_pkg::xm_cfg_words_t cfg_words;
  logic                       busy;
  logic                       job_req;
  logic                       writer_idle;

  xmatmul_issue_decode i_issue_decode (
    .issue_valid_i  ( issue_valid_i  ),
    .issue_req_i    ( issue_req_i    ),
    .busy_i         ( busy           ),
    .issue_ready_o  ( issue_ready_o  ),
    .issue_accept_o ( issue_accept_o ),
    .dec_o          ( dec            )
  );

  xmatmul_cfg_collect i_cfg_collect (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .clear_i       ( clear_i     ),
    .dec_i         ( dec         ),
    .writer_idle_i ( writer_idle ),
    .cfg_words_o   ( cfg_words   ),
    .job_req_o     ( job_req     ),
    .busy_o        ( busy        )
  );

  xmatmul_cfg_writer i_cfg_writer (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear_i        ),
    .job_req_i      ( job_req        ),
    .cfg_words_i    ( cfg_words      ),
    .cfg_complete_i ( cfg_complete_i ),
    .reg_gnt_i      ( reg_gnt_i      ),
    .reg_req_o      ( reg_req_o      ),
    .start_cfg_o    ( start_cfg_o    ),
    .idle_o         ( writer_idle    )
  );

endmodule

`default_nettype wire

// ==== bench/xmatmul_clk_rst.sv ====
/*
 * Clock and reset source for the offload testbench. Runs an 8 ns clock
 * and holds the active-low reset for the first four cycles.
 */

`timescale 1ns/1ps
`default_nettype none

module xmatmul_clk_rst (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (4) @(posedge clk_o);
    #1 rst_no = 1'b1; // Released just after an edge
  end

endmodule

`default_nettype wire

// ==== bench/xmatmul_offload_tb.sv ====
/*
 * Testbench for the offload front end. Applies a table of instructions to
 * the issue port, models the accelerator register file as a bus slave with
 * random grant stalls, and checks every write against a reference model.
 */

`timescale 1ns/1ps
`default_nettype none

module xmatmul_offload_tb;

  localparam int NumEntries = 15;
  localparam int CycleLimit = 200 * NumEntries;

  typedef logic [5:0][31:0] words_t;

  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] rs0;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic        rs_valid;
    logic        exp_ready;  // Ready in the first offered cycle
    logic        exp_accept;
    logic        job;        // A register-bus job follows
    logic        clr;        // Clear pulsed while that job is written
  } entry_t;

  logic                       clk;
  logic                       rst_n;
  logic                       clear;
  logic                       issue_valid;
  xmatmul_pkg::xm_issue_req_t issue_req;
  logic                       issue_ready;
  logic                       issue_accept;
  xmatmul_pkg::xm_reg_req_t   reg_req;
  logic                       reg_gnt;
  logic                       cfg_complete;
  logic                       start_cfg;

  entry_t                     stim [NumEntries];
  words_t                     model_words;
  words_t                     exp_jobs [$];  // Expected words of each job in flight
  xmatmul_pkg::xm_reg_req_t   prev_req;
  logic                       pending = 1'b0;
  logic                       cmpl_on = 1'b0;
  int                         cmpl_delay = -1;
  int                         stall_left = 0;
  int                         wr_idx = 0;     // 0..5 config words, 6 trigger
  int                         cycle_cnt = 0;
  logic [31:0]                lcg_state = 32'hf211_1015;

  xmatmul_clk_rst i_clk_rst (.clk_o(clk), .rst_no(rst_n));

  xmatmul_offload UUT (
    .clk_i          ( clk          ),
    .rst_ni         ( rst_n        ),
    .clear_i        ( clear        ),
    .issue_valid_i  ( issue_valid  ),
    .issue_req_i    ( issue_req    ),
    .issue_ready_o  ( issue_ready  ),
    .issue_accept_o ( issue_accept ),
    .reg_req_o      ( reg_req      ),
    .reg_gnt_i      ( reg_gnt      ),
    .cfg_complete_i ( cfg_complete ),
    .start_cfg_o    ( start_cfg    )
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic value_error(input string sig, input logic [79:0] got, input logic [79:0] exp);
    abort_run($sformatf("CHECK FAILED at %0t: %s is 0x%0h, expected 0x%0h",
                        $time, sig, got, exp));
  endtask

  function automatic int next_random(input int range);
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return int'((lcg_state >> 16) % range);
  endfunction

  // Flags are {rs_valid, exp_ready, exp_accept, job, clr}
  function automatic entry_t make_entry(input logic [31:0] instr, input logic [31:0] rs0,
                                        input logic [31:0] rs1, input logic [31:0] rs2,
                                        input logic [4:0] flags);
    return {instr, rs0, rs1, rs2, flags};
  endfunction

  task automatic load_table();
    stim[0]  = make_entry(32'h7C00_2573, 32'h0, 32'h0, 32'h0, 5'b0_11_0_0); // CSR macfg
    stim[1]  = make_entry(32'h3000_2573, 32'h0, 32'h0, 32'h0, 5'b0_10_0_0); // Foreign CSR
    stim[2]  = make_entry(32'h0020_81B3, 32'h0, 32'h0, 32'h0, 5'b0_10_0_0); // Unknown opcode
    stim[3]  = make_entry(32'h0020_800B, {16'd24, 16'd16}, 32'd32, 32'h0, 5'b1_11_0_0);
    stim[4]  = make_entry(32'h0062_A52B, 32'h1000_0000, 32'h1000_4000, 32'h1000_8000,
                          5'b1_11_1_0);
    stim[5]  = make_entry(32'h0020_800B, {16'd8, 16'd12}, 32'd20, 32'h0, 5'b1_01_0_0);
    stim[6]  = make_entry(32'h0062_A5AB, 32'h2000_0000, 32'h2000_1000, 32'h2000_2000,
                          5'b1_11_1_0);
    stim[7]  = make_entry(32'h00A4_B52B, 32'h0, 32'h0, 32'h0, 5'b0_01_0_0); // No operands
    stim[8]  = make_entry(32'h00A4_B5AB, 32'h3000_0000, 32'h3000_0400, 32'h3000_0800,
                          5'b1_11_1_0);
    stim[9]  = make_entry(32'h7C00_2573, 32'h0, 32'h0, 32'h0, 5'b0_11_0_0); // While busy
    stim[10] = make_entry(32'h0062_A52B, 32'h4000_0000, 32'h4000_0100, 32'h4000_0200,
                          5'b1_11_1_1);
    stim[11] = make_entry(32'h0062_A5AB, 32'h5000_0000, 32'h5000_0100, 32'h5000_0200,
                          5'b1_11_1_0);
    stim[12] = make_entry(32'h0020_800B, {16'd4, 16'd6}, 32'd10, 32'h0, 5'b1_01_0_0);
    stim[13] = make_entry(32'h0062_A52B, 32'h6000_0000, 32'h6000_0040, 32'h6000_0080,
                          5'b1_11_1_0);
    stim[14] = make_entry(32'h0000_007F, 32'h0, 32'h0, 32'h0, 5'b0_10_0_0);
  endtask

  // Reference model of the configuration word layout
  task automatic update_model(input entry_t e);
    if (e.instr[6:0] == 7'h0B && e.rs_valid) begin
      model_words[3] = e.rs0; // {K, M}
      model_words[4] = e.rs1; // N
    end
    if (e.instr[6:0] == 7'h2B) begin
      model_words[5] = e.instr;
      if (e.rs_valid) begin
        model_words[0] = e.rs0;
        model_words[1] = e.rs1;
        model_words[2] = e.rs2;
      end
    end
    if (e.job) exp_jobs.push_back(model_words);
  endtask

  task automatic wait_jobs_done();
    while (exp_jobs.size() != 0) @(posedge clk);
  endtask

  task automatic clear_mid_job();
    while (wr_idx < 2) @(posedge clk);
    #1;
    clear       = 1'b1;
    model_words = '0;
    @(posedge clk);
    #1;
    clear = 1'b0;
    @(negedge clk);
    assert (!reg_req.req) else value_error("reg_req_o.req", reg_req.req, 1'b0);
  endtask

  task automatic apply_entry(input entry_t e);
    @(posedge clk);
    #1;
    issue_valid        = 1'b1;
    issue_req.instr    = e.instr;
    issue_req.rs[0]    = e.rs0;
    issue_req.rs[1]    = e.rs1;
    issue_req.rs[2]    = e.rs2;
    issue_req.rs_valid = e.rs_valid;
    @(negedge clk);
    assert (issue_ready == e.exp_ready)
      else value_error("issue_ready_o", issue_ready, e.exp_ready);
    while (!issue_ready) @(negedge clk); // Core holds the instruction
    assert (issue_accept == e.exp_accept)
      else value_error("issue_accept_o", issue_accept, e.exp_accept);
    if (!e.exp_ready) begin
      assert (exp_jobs.size() == 0)
        else abort_run("Held instruction was taken before the trigger write");
    end
    update_model(e);
    @(posedge clk);
    #1;
    issue_valid = 1'b0;
    if (e.clr) clear_mid_job();
  endtask

  initial begin : drive
    entry_t e;
    clear       = 1'b0;
    issue_valid = 1'b0;
    issue_req   = '0;
    model_words = '0;
    load_table();
    @(posedge rst_n);
    for (int i = 0; i < NumEntries; i++) begin
      e = stim[i];
      // Free-running MCNFIG/MARITH entries wait until the last job is done
      if ((e.instr[6:0] == 7'h0B || e.instr[6:0] == 7'h2B) && e.exp_ready) wait_jobs_done();
      apply_entry(e);
    end
    wait_jobs_done();
    repeat (4) @(posedge clk);
    $display("=== PASS ===");
    $finish;
  end

  // Slave outputs change just after the rising edge
  initial begin : slave_drive
    reg_gnt      = 1'b0;
    cfg_complete = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      reg_gnt = (stall_left == 0);
      if (cmpl_delay == 0) cmpl_on = 1'b1;
      if (cmpl_delay >= 0) cmpl_delay--;
      cfg_complete = cmpl_on;
    end
  end

  always @(negedge clk) begin : bus_monitor
    logic        hs;
    logic [31:0] exp_add;
    logic [31:0] exp_data;
    if (rst_n) begin
      hs = reg_req.req && reg_gnt;
      assert (start_cfg == (hs && wr_idx == 5))
        else value_error("start_cfg_o", start_cfg, hs && wr_idx == 5);
      if (wr_idx == 6 && !cfg_complete) begin
        assert (!reg_req.req) else abort_run("Trigger write requested before cfg_complete_i");
      end
      if (pending) begin
        assert (reg_req == prev_req) else value_error("reg_req_o", reg_req, prev_req);
      end
      if (hs) begin
        assert (exp_jobs.size() != 0)
          else abort_run("Register write seen with no job in flight");
        exp_add  = (wr_idx < 6) ? 32'h40 + 32'(4 * wr_idx) : 32'h0;
        exp_data = (wr_idx < 6) ? exp_jobs[0][wr_idx] : 32'h0;
        assert (reg_req.add == exp_add) else value_error("reg_req_o.add", reg_req.add, exp_add);
        assert (reg_req.data == exp_data)
          else value_error("reg_req_o.data", reg_req.data, exp_data);
        assert ({reg_req.wen, reg_req.be, reg_req.id} == 9'h0F0)
          else value_error("reg_req_o.wen/be/id", {reg_req.wen, reg_req.be, reg_req.id}, 9'h0F0);
        if (wr_idx == 6) begin
          exp_jobs.delete(0);
          wr_idx  = 0;
          cmpl_on = 1'b0;
        end else begin
          wr_idx++;
        end
        stall_left = next_random(4);
      end else if (reg_req.req && stall_left > 0) begin
        stall_left--;
      end
      if (start_cfg) begin
        cmpl_delay = next_random(5);
      end
      pending  = reg_req.req && !reg_gnt && !clear;
      prev_req = reg_req;
      if (clear) begin
        if (exp_jobs.size() != 0) exp_jobs.delete(0); // Job abandoned
        wr_idx     = 0;
        cmpl_on    = 1'b0;
        cmpl_delay = -1;
      end
    end
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  initial begin : watchdog
    wait (cycle_cnt >= CycleLimit);
    abort_run($sformatf("Timeout after %0d cycles, the DUT stopped making progress",
                        CycleLimit));
  end

endmodule

`default_nettype wire

// ==== xmatmul_offload.f ====
hw/xmatmul_pkg.sv
hw/xmatmul_issue_decode.sv
hw/xmatmul_cfg_collect.sv
hw/xmatmul_cfg_writer.sv
hw/xmatmul_offload.sv
bench/xmatmul_clk_rst.sv
bench/xmatmul_offload_tb.sv

// ==== Bender.yml ====
package:
  name: xmatmul_offload

sources:
  - hw/xmatmul_pkg.sv
  - hw/xmatmul_issue_decode.sv
  - hw/xmatmul_cfg_collect.sv
  - hw/xmatmul_cfg_writer.sv
  - hw/xmatmul_offload.sv
  - target: test
    files:
      - bench/xmatmul_clk_rst.sv
      - bench/xmatmul_offload_tb.sv
